// ==== verilog/kbd_pkg.sv ====
package kbd_pkg;

  // bits per ps/2 word: start, 8 data, parity, stop
  localparam int KBD_FRAME_BITS = 11;

  // release prefix, the next code is the key that went up
  localparam logic [7:0] KBD_BREAK_CODE = 8'hF0;

  // extended prefix, marks keys from the second code page
  localparam logic [7:0] KBD_EXT_CODE = 8'hE0;

  // one serial word as it lands in the shift register
  // data is lsb first on the wire, so start ends up in bit 0
  typedef struct packed {
    logic       stop;
    logic       odd_parity;
    logic [7:0] data;
    logic       start;
  } t_kbd_frame;

  // one delivered key release
  typedef struct packed {
    // set when an E0 came before the break
    logic       extended;
    // released key, or the raw byte of a bad frame
    logic [7:0] code;
    // start, stop or parity check failed
    logic       frame_error;
  } t_kbd_entry;

  // control register write word
  typedef struct packed {
    // level, gates pushes in the kbd_clk domain
    logic enable;
    // write one to drop the sticky error
    logic clear_error;
  } t_kbd_ctrl;

endpackage

// ==== verilog/kbd_frame_receiver.sv ====
module kbd_frame_receiver (
  // ps/2 lines, both sampled on the rising kbd_clk
  input  logic                kbd_clk,
  input  logic                kbd_data,
  // core-domain level and reset, synchronized below
  input  logic                enable,
  input  logic                rst_n,
  // reset for the fifo write side, already in kbd_clk
  output logic                kbd_rst_n,
  // one pulse per release, entry valid with it
  output logic                push,
  output kbd_pkg::t_kbd_entry push_entry
);
  import kbd_pkg::*;

  // counter value seen just before the last bit arrives
  localparam logic [3:0] LAST_BIT = 4'(KBD_FRAME_BITS - 1);

  logic [1:0] rst_sync;
  logic [1:0] en_sync;
  logic       enable_kc;
  logic       hold_idle;
  t_kbd_frame shift_q;
  t_kbd_frame frame_next;
  logic [3:0] bit_cnt;
  logic       frame_end;
  logic       frame_ok;
  logic       is_break;
  logic       is_ext;
  logic       break_flag;
  logic       ext_flag;

  // two flops for the core reset, kbd_clk only runs during traffic
  // so the tb gives idle pulses after reset to flush this
  always_ff @(posedge kbd_clk) begin
    rst_sync <= {rst_sync[0], rst_n};
  end
  assign kbd_rst_n = rst_sync[1];

  // enable crosses the same way, cleared by the local reset
  always_ff @(posedge kbd_clk) begin
    if (!kbd_rst_n) begin
      en_sync <= '0;
    end else begin
      en_sync <= {en_sync[0], enable};
    end
  end
  assign enable_kc = en_sync[1];

  // disabled acts as reset for the framing state
  assign hold_idle = !kbd_rst_n || !enable_kc;

  // shift right, newest bit enters at the stop position
  // after 11 edges the start bit sits in bit 0
  assign frame_next = {kbd_data, shift_q[KBD_FRAME_BITS-1:1]};

  always_ff @(posedge kbd_clk) begin
    shift_q <= frame_next;
  end

  // this edge brings in the stop bit
  assign frame_end = (bit_cnt == LAST_BIT);

  // start low, stop high, odd count of ones over data and parity
  assign frame_ok = !frame_next.start && frame_next.stop &&
                    (^{frame_next.odd_parity, frame_next.data});

  assign is_break = (frame_next.data == KBD_BREAK_CODE);
  assign is_ext   = (frame_next.data == KBD_EXT_CODE);

  // bit counter
  // 0 is idle, a low data bit on an idle edge is the start bit
  always_ff @(posedge kbd_clk) begin
    if (hold_idle) begin
      bit_cnt <= '0;
    end else if (bit_cnt == '0) begin
      if (!kbd_data) begin
        bit_cnt <= 4'd1;
      end
    end else if (frame_end) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  // prefix tracking and push
  // push is registered on the last edge, so the fifo
  // takes the entry on the kbd_clk edge after it
  always_ff @(posedge kbd_clk) begin
    if (hold_idle) begin
      push       <= 1'b0;
      break_flag <= 1'b0;
      ext_flag   <= 1'b0;
    end else begin
      push <= 1'b0;
      if (frame_end) begin
        if (!frame_ok) begin
          // bad word always goes out, prefixes are lost
          push       <= 1'b1;
          break_flag <= 1'b0;
          ext_flag   <= 1'b0;
        end else if (is_break) begin
          break_flag <= 1'b1;
        end else if (is_ext) begin
          ext_flag <= 1'b1;
        end else begin
          // key code, a make is dropped here
          push       <= break_flag;
          break_flag <= 1'b0;
          ext_flag   <= 1'b0;
        end
      end
    end
  end

  // entry payload, only looked at together with push
  always_ff @(posedge kbd_clk) begin
    if (frame_end) begin
      push_entry.extended    <= ext_flag;
      push_entry.code        <= frame_next.data;
      push_entry.frame_error <= !frame_ok;
    end
  end

  // a push belongs to a finished word, never to one in flight
  a_push_between_frames : assert property (
    @(posedge kbd_clk) disable iff (!kbd_rst_n)
    push |-> (bit_cnt == '0) && $past(frame_end)
  );

endmodule

// ==== verilog/kbd_gray_fifo.sv ====
module kbd_gray_fifo #(
  parameter int FIFO_DEPTH_LOG2 = 3
) (
  // write side clock and reset
  input  logic                kbd_clk,
  // read side clock and reset
  input  logic                core_clk,
  input  logic                kbd_rst_n,
  input  logic                rst_n,
  // write port, kbd_clk
  input  logic                push,
  input  kbd_pkg::t_kbd_entry push_entry,
  // read port, core_clk
  input  logic                read_en,
  output logic                read_valid,
  output kbd_pkg::t_kbd_entry read_entry,
  // not empty, as seen from the core side
  output logic                data_ready
);
  import kbd_pkg::*;

  localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
  // one extra bit tells a full ring from an empty one
  localparam int PTR_W = FIFO_DEPTH_LOG2 + 1;
  // in gray code, full means the top two bits differ, rest equal
  localparam logic [PTR_W-1:0] FULL_MASK = PTR_W'(3) << (PTR_W - 2);

  t_kbd_entry mem [DEPTH];

  logic [PTR_W-1:0] wbin;
  logic [PTR_W-1:0] wbin_next;
  logic [PTR_W-1:0] wgray;
  logic [PTR_W-1:0] wgray_next;
  logic [PTR_W-1:0] rbin;
  logic [PTR_W-1:0] rbin_next;
  logic [PTR_W-1:0] rgray;
  logic [PTR_W-1:0] rgray_next;
  // read pointer seen in kbd_clk
  logic [PTR_W-1:0] rgray_kc1;
  logic [PTR_W-1:0] rgray_kc2;
  // write pointer seen in core_clk
  logic [PTR_W-1:0] wgray_cc1;
  logic [PTR_W-1:0] wgray_cc2;
  logic             full;
  logic             empty;
  logic             do_write;
  logic             do_read;

  // write side
  assign wbin_next  = wbin + PTR_W'(1);
  assign wgray_next = (wbin_next >> 1) ^ wbin_next;
  assign full       = (wgray == (rgray_kc2 ^ FULL_MASK));
  // push into a full ring is simply lost
  assign do_write   = push && !full;

  always_ff @(posedge kbd_clk) begin
    if (!kbd_rst_n) begin
      wbin  <= '0;
      wgray <= '0;
    end else if (do_write) begin
      wbin  <= wbin_next;
      wgray <= wgray_next;
    end
  end

  always_ff @(posedge kbd_clk) begin
    if (do_write) begin
      mem[wbin[FIFO_DEPTH_LOG2-1:0]] <= push_entry;
    end
  end

  // full may read stale, which only makes it pessimistic
  always_ff @(posedge kbd_clk) begin
    if (!kbd_rst_n) begin
      rgray_kc1 <= '0;
      rgray_kc2 <= '0;
    end else begin
      rgray_kc1 <= rgray;
      rgray_kc2 <= rgray_kc1;
    end
  end

  // read side
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      wgray_cc1 <= '0;
      wgray_cc2 <= '0;
    end else begin
      wgray_cc1 <= wgray;
      wgray_cc2 <= wgray_cc1;
    end
  end

  // a new entry shows up two to three core edges after the write
  assign empty      = (rgray == wgray_cc2);
  assign data_ready = !empty;
  // strobes on an empty ring are dropped
  assign do_read    = read_en && !empty;
  assign rbin_next  = rbin + PTR_W'(1);
  assign rgray_next = (rbin_next >> 1) ^ rbin_next;

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      rbin  <= '0;
      rgray <= '0;
    end else if (do_read) begin
      rbin  <= rbin_next;
      rgray <= rgray_next;
    end
  end

  // registered read port, one cycle after read_en
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= do_read;
    end
  end

  always_ff @(posedge core_clk) begin
    if (do_read) begin
      read_entry <= mem[rbin[FIFO_DEPTH_LOG2-1:0]];
    end
  end

  // each advance flips a single gray bit, or the sync could tear
  a_wgray_one_bit : assert property (
    @(posedge kbd_clk) disable iff (!kbd_rst_n)
    $onehot0(wgray ^ $past(wgray))
  );

  a_rgray_one_bit : assert property (
    @(posedge core_clk) disable iff (!rst_n)
    $onehot0(rgray ^ $past(rgray))
  );

  // a popped entry was announced the cycle before
  a_valid_after_ready : assert property (
    @(posedge core_clk) disable iff (!rst_n)
    read_valid |-> $past(data_ready)
  );

endmodule

// ==== verilog/kbd_ctrl_regs.sv ====
module kbd_ctrl_regs (
  input  logic                core_clk,
  input  logic                rst_n,
  // register write strobe and word
  input  logic                reg_wr,
  input  kbd_pkg::t_kbd_ctrl  reg_wdata,
  // popped entries, watched for the error bit
  input  logic                read_valid,
  input  kbd_pkg::t_kbd_entry read_entry,
  // level to the receiver, crossed into kbd_clk there
  output logic                enable,
  // sticky until software clears it
  output logic                error
);

  logic set_error;
  logic clear_error;

  // bad frame reached the core
  assign set_error = read_valid && read_entry.frame_error;

  // clear only counts on a real write
  assign clear_error = reg_wr && reg_wdata.clear_error;

  // enable register
  // disabling stops new pushes, entries already queued stay readable
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      enable <= 1'b0;
    end else if (reg_wr) begin
      enable <= reg_wdata.enable;
    end
  end

  // sticky error
  // a pop and a clear on the same edge leave it set
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      error <= 1'b0;
    end else if (set_error) begin
      error <= 1'b1;
    end else if (clear_error) begin
      error <= 1'b0;
    end
  end

endmodule

// ==== verilog/kbd_controller_top.sv ====
module kbd_controller_top #(
  parameter int FIFO_DEPTH_LOG2 = 3
) (
  // core side
  input  logic                core_clk,
  input  logic                rst_n,
  // ps/2 lines
  input  logic                kbd_clk,
  input  logic                kbd_data,
  // control register write
  input  logic                reg_wr,
  input  kbd_pkg::t_kbd_ctrl  reg_wdata,
  // entry read port and status
  input  logic                read_en,
  output logic                read_valid,
  output kbd_pkg::t_kbd_entry read_entry,
  output logic                data_ready,
  output logic                error
);
  import kbd_pkg::*;

  // enable level, core_clk
  logic       enable;
  // kbd_clk domain signals
  logic       kbd_rst_n;
  logic       push;
  t_kbd_entry push_entry;

  kbd_frame_receiver i_rx (
    .kbd_clk    (kbd_clk),
    .kbd_data   (kbd_data),
    .enable     (enable),
    .rst_n      (rst_n),
    .kbd_rst_n  (kbd_rst_n),
    .push       (push),
    .push_entry (push_entry)
  );

  kbd_gray_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) i_fifo (
    .kbd_clk    (kbd_clk),
    .core_clk   (core_clk),
    .kbd_rst_n  (kbd_rst_n),
    .rst_n      (rst_n),
    .push       (push),
    .push_entry (push_entry),
    .read_en    (read_en),
    .read_valid (read_valid),
    .read_entry (read_entry),
    .data_ready (data_ready)
  );

  // sits beside the fifo, sees the same popped entries the core does
  kbd_ctrl_regs i_regs (
    .core_clk   (core_clk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_wdata  (reg_wdata),
    .read_valid (read_valid),
    .read_entry (read_entry),
    .enable     (enable),
    .error      (error)
  );

endmodule

// ==== tb/kbd_checker.sv ====
module kbd_checker (
  input  logic                core_clk,
  input  logic                rst_n,
  // toggles once per frame sent, frame_word holds that frame
  input  logic                frame_tog,
  input  kbd_pkg::t_kbd_frame frame_word,
  // register writes, watched to follow enable and clear_error
  input  logic                reg_wr,
  input  kbd_pkg::t_kbd_ctrl  reg_wdata,
  // dut outputs under test
  input  logic                read_valid,
  input  kbd_pkg::t_kbd_entry read_entry,
  input  logic                data_ready,
  input  logic                error,
  // entries predicted but not yet read
  output int                  pending,
  output int                  errors,
  output int                  checks
);
  import kbd_pkg::*;

  t_kbd_entry exp_q[$];
  t_kbd_entry head;
  logic       last_tog;
  logic       en_model;
  logic       brk_flag;
  logic       ext_flag;
  logic       exp_error;
  logic       pop_error;

  initial begin
    pending = 0;
    errors  = 0;
    checks  = 0;
  end

  // receiver rules applied to one finished frame
  task automatic model_frame(input t_kbd_frame f);
    int         ones;
    logic       good;
    t_kbd_entry e;
    ones = $countones({f.odd_parity, f.data});
    good = (f.start == 1'b0) && (f.stop == 1'b1) && (ones % 2 == 1);
    e.extended    = ext_flag;
    e.code        = f.data;
    e.frame_error = !good;
    if (!en_model) begin
      // disabled, the word is ignored and prefixes stay clear
      brk_flag = 1'b0;
      ext_flag = 1'b0;
    end else if (!good) begin
      exp_q.push_back(e);
      brk_flag = 1'b0;
      ext_flag = 1'b0;
    end else if (f.data == KBD_BREAK_CODE) begin
      brk_flag = 1'b1;
    end else if (f.data == KBD_EXT_CODE) begin
      ext_flag = 1'b1;
    end else begin
      // only a release is delivered
      if (brk_flag) begin
        exp_q.push_back(e);
      end
      brk_flag = 1'b0;
      ext_flag = 1'b0;
    end
  endtask

  always @(posedge core_clk) begin
    if (!rst_n) begin
      exp_q.delete();
      last_tog  = frame_tog;
      en_model  = 1'b0;
      brk_flag  = 1'b0;
      ext_flag  = 1'b0;
      exp_error = 1'b0;
    end else begin
      // sticky error level for this cycle
      checks++;
      if (error !== exp_error) begin
        errors++;
        $display("ERROR error expected %h got %h", exp_error, error);
      end
      // ready may lag the model but never lead it
      if (data_ready && exp_q.size() <= int'(read_valid)) begin
        errors++;
        $display("data_ready is high at %0t but no entry is expected", $time);
      end
      pop_error = 1'b0;
      if (read_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("read_valid at %0t with no entry expected", $time);
        end else begin
          head = exp_q.pop_front();
          checks++;
          if (read_entry !== head) begin
            errors++;
            $display("ERROR read_entry expected %h got %h", head, read_entry);
          end
          pop_error = head.frame_error;
        end
      end
      // a popped bad entry beats a clear in the same cycle
      if (pop_error) begin
        exp_error = 1'b1;
      end else if (reg_wr && reg_wdata.clear_error) begin
        exp_error = 1'b0;
      end
      if (reg_wr) begin
        en_model = reg_wdata.enable;
        if (!reg_wdata.enable) begin
          brk_flag = 1'b0;
          ext_flag = 1'b0;
        end
      end
      // new frame from the driver
      if (frame_tog != last_tog) begin
        last_tog = frame_tog;
        model_frame(frame_word);
      end
    end
    pending = exp_q.size();
  end

endmodule

// ==== tb/tb_kbd_controller.sv ====
module tb_kbd_controller;
  import kbd_pkg::*;

  localparam int NUM_FRAMES    = 140;
  localparam int KBD_HALF      = 100;
  // frames times bits times kbd period, doubled, plus margin
  localparam int WATCHDOG_TIME = NUM_FRAMES * KBD_FRAME_BITS * 200 * 2 + 10000;

  logic       core_clk;
  logic       rst_n;
  logic       kbd_clk;
  logic       kbd_data;
  logic       reg_wr;
  t_kbd_ctrl  reg_wdata;
  logic       read_en;
  logic       read_valid;
  t_kbd_entry read_entry;
  logic       data_ready;
  logic       error;
  // frame handoff to the checker
  logic       frame_tog;
  t_kbd_frame frame_word;
  int         pending;
  int         chk_errors;
  int         chk_checks;
  // stimulus state
  int         seed;
  int         tb_errors;
  int         test_num;
  int         errors_before;
  int         gap;
  int         read_count;
  logic       reading_on;
  logic       probe_reads;
  logic       en_state;

  kbd_controller_top #(
    .FIFO_DEPTH_LOG2 (3)
  ) i_dut (
    .core_clk   (core_clk),
    .rst_n      (rst_n),
    .kbd_clk    (kbd_clk),
    .kbd_data   (kbd_data),
    .reg_wr     (reg_wr),
    .reg_wdata  (reg_wdata),
    .read_en    (read_en),
    .read_valid (read_valid),
    .read_entry (read_entry),
    .data_ready (data_ready),
    .error      (error)
  );

  kbd_checker i_chk (
    .core_clk   (core_clk),
    .rst_n      (rst_n),
    .frame_tog  (frame_tog),
    .frame_word (frame_word),
    .reg_wr     (reg_wr),
    .reg_wdata  (reg_wdata),
    .read_valid (read_valid),
    .read_entry (read_entry),
    .data_ready (data_ready),
    .error      (error),
    .pending    (pending),
    .errors     (chk_errors),
    .checks     (chk_checks)
  );

  initial begin
    core_clk = 1'b0;
    forever #10 core_clk = ~core_clk;
  end

  // run limit
  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired at %0t, the run did not finish", $time);
    $display("Errors found");
    $finish;
  end

  // core side reader, pops soon after data_ready with a varying gap
  always @(posedge core_clk) begin
    if (!rst_n) begin
      read_en <= 1'b0;
      gap     <= 0;
    end else if (read_en) begin
      read_en <= 1'b0;
    end else if (gap > 0) begin
      gap <= gap - 1;
    end else if (reading_on && (data_ready || probe_reads)) begin
      read_en    <= 1'b1;
      gap        <= read_count % 4;
      read_count <= read_count + 1;
    end
  end

  // odd parity, with optional parity or stop fault
  function automatic t_kbd_frame make_frame(input logic [7:0] data, input logic bad_parity,
                                            input logic bad_stop);
    t_kbd_frame f;
    f.start      = 1'b0;
    f.data       = data;
    f.odd_parity = (~^data) ^ bad_parity;
    f.stop       = !bad_stop;
    return f;
  endfunction

  // random key code that is not a prefix
  function automatic logic [7:0] pick_code();
    logic [7:0] c;
    c = $random(seed);
    if (c == KBD_BREAK_CODE || c == KBD_EXT_CODE) begin
      c = c ^ 8'h01;
    end
    return c;
  endfunction

  // idle clock pulses, data held high
  task automatic kbd_pulses(input int n, input int half);
    repeat (n) begin
      kbd_data <= 1'b1;
      #(half) kbd_clk <= 1'b1;
      #(half) kbd_clk <= 1'b0;
    end
  endtask

  // start bit first, data lsb first, one idle pulse after the stop bit
  task automatic send_frame(input t_kbd_frame f);
    frame_word <= f;
    for (int i = 0; i < KBD_FRAME_BITS; i++) begin
      kbd_data <= f[i];
      #(KBD_HALF) kbd_clk <= 1'b1;
      #(KBD_HALF) kbd_clk <= 1'b0;
    end
    frame_tog <= ~frame_tog;
    kbd_pulses(1, KBD_HALF);
  endtask

  task automatic send_release(input logic [7:0] code, input logic ext);
    if (ext) begin
      send_frame(make_frame(KBD_EXT_CODE, 1'b0, 1'b0));
    end
    send_frame(make_frame(KBD_BREAK_CODE, 1'b0, 1'b0));
    send_frame(make_frame(code, 1'b0, 1'b0));
  endtask

  task automatic send_bad(input logic [7:0] code, input logic stop_fault);
    send_frame(make_frame(code, !stop_fault, stop_fault));
  endtask

  task automatic ctrl_write(input logic en, input logic clr);
    @(posedge core_clk);
    reg_wr                <= 1'b1;
    reg_wdata.enable      <= en;
    reg_wdata.clear_error <= clr;
    @(posedge core_clk);
    reg_wr    <= 1'b0;
    reg_wdata <= '0;
    en_state = en;
  endtask

  // read everything out, then wait for a quiet stretch
  task automatic drain();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    reading_on <= 1'b1;
    kbd_pulses(2, KBD_HALF);
    while (quiet < 8 && waited < 400) begin
      @(negedge core_clk);
      waited++;
      if (pending == 0 && !data_ready && !read_valid) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet < 8) begin
      tb_errors++;
      $display("drain timed out with %0d expected entries never read", pending);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = chk_errors + tb_errors - errors_before;
    test_num++;
    $display("test %0d %-24s %s, %0d errors", test_num, name, (errs == 0) ? "pass" : "FAIL",
             errs);
    errors_before = chk_errors + tb_errors;
  endtask

  initial begin
    int waited;
    int kind;
    seed          = 32'h22a4;
    tb_errors     = 0;
    test_num      = 0;
    errors_before = 0;
    read_count    = 0;
    en_state      = 1'b0;
    rst_n       <= 1'b0;
    kbd_clk     <= 1'b0;
    kbd_data    <= 1'b1;
    reg_wr      <= 1'b0;
    reg_wdata   <= '0;
    read_en     <= 1'b0;
    frame_tog   <= 1'b0;
    frame_word  <= '0;
    reading_on  <= 1'b0;
    probe_reads <= 1'b0;
    // two quick pulses so the kbd_clk side samples the reset
    fork
      kbd_pulses(2, 15);
    join_none
    repeat (4) @(posedge core_clk);
    rst_n <= 1'b1;
    kbd_pulses(4, KBD_HALF);
    ctrl_write(1'b1, 1'b0);
    kbd_pulses(4, KBD_HALF);
    reading_on <= 1'b1;

    // plain releases
    repeat (4) send_release(pick_code(), 1'b0);
    drain();
    end_test("release");

    repeat (3) send_release(pick_code(), 1'b1);
    drain();
    end_test("extended release");

    // makes and a lone E0, then strobes on an empty fifo
    repeat (3) send_frame(make_frame(pick_code(), 1'b0, 1'b0));
    send_frame(make_frame(KBD_EXT_CODE, 1'b0, 1'b0));
    send_frame(make_frame(pick_code(), 1'b0, 1'b0));
    kbd_pulses(2, KBD_HALF);
    @(posedge core_clk);
    probe_reads <= 1'b1;
    repeat (20) @(posedge core_clk);
    probe_reads <= 1'b0;
    drain();
    end_test("make and lone prefix");

    // bad parity after F0, bad stop after E0, a make after each
    send_frame(make_frame(KBD_BREAK_CODE, 1'b0, 1'b0));
    send_bad(pick_code(), 1'b0);
    send_frame(make_frame(pick_code(), 1'b0, 1'b0));
    send_frame(make_frame(KBD_EXT_CODE, 1'b0, 1'b0));
    send_bad(pick_code(), 1'b1);
    send_frame(make_frame(pick_code(), 1'b0, 1'b0));
    drain();
    ctrl_write(1'b1, 1'b1);
    repeat (4) @(posedge core_clk);
    end_test("bad frame and error");

    ctrl_write(1'b0, 1'b0);
    kbd_pulses(4, KBD_HALF);
    repeat (2) send_release(pick_code(), $random(seed) & 1);
    drain();
    ctrl_write(1'b1, 1'b0);
    kbd_pulses(4, KBD_HALF);
    repeat (2) send_release(pick_code(), $random(seed) & 1);
    drain();
    end_test("enable gating");

    // fill without reading, then empty it in one go
    reading_on <= 1'b0;
    repeat (8) send_release(pick_code(), $random(seed) & 1);
    kbd_pulses(2, KBD_HALF);
    waited = 0;
    while (!data_ready && waited < 50) begin
      @(negedge core_clk);
      waited++;
    end
    if (!data_ready) begin
      tb_errors++;
      $display("data_ready never rose with eight entries queued");
    end
    reading_on <= 1'b1;
    waited = 0;
    while (pending != 0 && waited < 400) begin
      @(negedge core_clk);
      waited++;
      if (!data_ready && pending > int'(read_valid)) begin
        tb_errors++;
        $display("data_ready fell with %0d entries still queued", pending);
      end
    end
    drain();
    end_test("eight queued releases");

    // random mix, enable toggles and clears between frames
    repeat (24) begin
      kind = $random(seed) & 7;
      case (kind)
        0, 1, 2: send_release(pick_code(), $random(seed) & 1);
        3: send_frame(make_frame(pick_code(), 1'b0, 1'b0));
        4: send_bad($random(seed), $random(seed) & 1);
        5: begin
          ctrl_write(!en_state, 1'b0);
          kbd_pulses(4, KBD_HALF);
        end
        6: ctrl_write(en_state, 1'b1);
        default: begin
          if ($random(seed) & 1) begin
            send_frame(make_frame(KBD_BREAK_CODE, 1'b0, 1'b0));
          end else begin
            send_frame(make_frame(KBD_EXT_CODE, 1'b0, 1'b0));
          end
        end
      endcase
    end
    if (!en_state) begin
      ctrl_write(1'b1, 1'b0);
      kbd_pulses(4, KBD_HALF);
    end
    drain();
    end_test("random mix");

    $display("tests %0d, checks %0d, errors %0d", test_num, chk_checks,
             chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
verilog/kbd_pkg.sv
verilog/kbd_frame_receiver.sv
verilog/kbd_gray_fifo.sv
verilog/kbd_ctrl_regs.sv
verilog/kbd_controller_top.sv
tb/kbd_checker.sv
tb/tb_kbd_controller.sv
